// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_cpu
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' all.f) tb/tb_tests.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) all.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f all.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+tb
logic/mips_pkg.sv
logic/exec_if.sv
logic/register_file.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/bus_sequencer.sv
logic/mips_cpu_bus.sv
tb/tb_mips_cpu.sv

// File: logic/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import mips_pkg::*; (
    exec_if.alu                   ex,
    output logic [XLEN-1:0]       result,
    output logic                  wr_en,
    output logic [REG_ADDR_W-1:0] wr_reg,
    output logic [XLEN-1:0]       mem_addr,
    output logic                  is_load,
    output logic                  is_store
);

    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] imm_zext;

    assign imm_sext = {{(XLEN-16){ex.instr.i.imm[15]}}, ex.instr.i.imm};
    assign imm_zext = {{(XLEN-16){1'b0}}, ex.instr.i.imm};

    // Base plus offset for LW and SW
    assign mem_addr = ex.rs_val + imm_sext;

    always_comb begin
        result   = '0;
        wr_en    = 1'b0;
        wr_reg   = ex.instr.i.rt;
        is_load  = 1'b0;
        is_store = 1'b0;
        case (ex.instr.r.opcode)
            OP_RTYPE: begin
                wr_reg = ex.instr.r.rd;
                wr_en  = 1'b1;
                case (ex.instr.r.funct)
                    FN_ADDU: result = ex.rs_val + ex.rt_val;
                    FN_SUBU: result = ex.rs_val - ex.rt_val;
                    FN_AND:  result = ex.rs_val & ex.rt_val;
                    FN_OR:   result = ex.rs_val | ex.rt_val;
                    FN_XOR:  result = ex.rs_val ^ ex.rt_val;
                    FN_SLT:  result = XLEN'($signed(ex.rs_val) < $signed(ex.rt_val));
                    FN_SLTU: result = XLEN'(ex.rs_val < ex.rt_val);
                    FN_SLL:  result = ex.rt_val << ex.instr.r.shamt;
                    FN_SRL:  result = ex.rt_val >> ex.instr.r.shamt;
                    FN_SRA:  result = $signed(ex.rt_val) >>> ex.instr.r.shamt;
                    // JR and JALR belong to the branch unit
                    default: wr_en = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                result = ex.rs_val + imm_sext;
                wr_en  = 1'b1;
            end
            OP_SLTI: begin
                result = XLEN'($signed(ex.rs_val) < $signed(imm_sext));
                wr_en  = 1'b1;
            end
            OP_SLTIU: begin
                result = XLEN'(ex.rs_val < imm_sext);
                wr_en  = 1'b1;
            end
            OP_ANDI: begin
                result = ex.rs_val & imm_zext;
                wr_en  = 1'b1;
            end
            OP_ORI: begin
                result = ex.rs_val | imm_zext;
                wr_en  = 1'b1;
            end
            OP_XORI: begin
                result = ex.rs_val ^ imm_zext;
                wr_en  = 1'b1;
            end
            OP_LUI: begin
                result = {ex.instr.i.imm, 16'h0000};
                wr_en  = 1'b1;
            end
            // Load data arrives later, the sequencer writes it back
            OP_LW:   is_load  = 1'b1;
            OP_SW:   is_store = 1'b1;
            default: wr_en    = 1'b0;
        endcase
    end

endmodule

// File: logic/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import mips_pkg::*; (
    exec_if.branch                ex,
    output logic                  redirect,
    output logic [XLEN-1:0]       target,
    output logic                  link_en,
    output logic [REG_ADDR_W-1:0] link_reg,
    output logic [XLEN-1:0]       link_val
);

    logic [XLEN-1:0] branch_target;
    logic [XLEN-1:0] jump_target;

    // Word offset relative to the delay slot address
    assign branch_target = ex.pc_plus4 +
        {{(XLEN-18){ex.instr.i.imm[15]}}, ex.instr.i.imm, 2'b00};
    assign jump_target = {ex.pc_plus4[XLEN-1:XLEN-4], ex.instr.j.index, 2'b00};

    // Return lands after the delay slot
    assign link_val = ex.pc_plus4 + XLEN'(4);

    always_comb begin
        redirect = 1'b0;
        target   = branch_target;
        link_en  = 1'b0;
        link_reg = REG_RA;
        case (ex.instr.j.opcode)
            OP_BEQ: redirect = (ex.rs_val == ex.rt_val);
            OP_BNE: redirect = (ex.rs_val != ex.rt_val);
            OP_J: begin
                redirect = 1'b1;
                target   = jump_target;
            end
            OP_JAL: begin
                redirect = 1'b1;
                target   = jump_target;
                link_en  = 1'b1;
            end
            OP_RTYPE: begin
                target = ex.rs_val;
                if (ex.instr.r.funct == FN_JR) begin
                    redirect = 1'b1;
                end else if (ex.instr.r.funct == FN_JALR) begin
                    redirect = 1'b1;
                    link_en  = 1'b1;
                    link_reg = ex.instr.r.rd;
                end
            end
            default: redirect = 1'b0;
        endcase
    end

endmodule

// File: logic/bus_sequencer.sv
`timescale 1ns/1ps

module bus_sequencer import mips_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_VECTOR = 32'hBFC0_0000
) (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  active,
    output logic [XLEN-1:0]       address,
    output logic                  read,
    output logic                  write,
    input  logic                  waitrequest,
    output logic [XLEN-1:0]       writedata,
    output logic [3:0]            byteenable,
    input  logic [XLEN-1:0]       readdata,
    output logic [REG_ADDR_W-1:0] rs_addr,
    output logic [REG_ADDR_W-1:0] rt_addr,
    input  logic [XLEN-1:0]       rs_val,
    input  logic [XLEN-1:0]       rt_val,
    exec_if.seq                   ex,
    input  logic [XLEN-1:0]       result,
    input  logic                  wr_en,
    input  logic [REG_ADDR_W-1:0] wr_reg,
    input  logic [XLEN-1:0]       mem_addr,
    input  logic                  is_load,
    input  logic                  is_store,
    input  logic                  redirect,
    input  logic [XLEN-1:0]       target,
    input  logic                  link_en,
    input  logic [REG_ADDR_W-1:0] link_reg,
    input  logic [XLEN-1:0]       link_val,
    output logic                  we,
    output logic [REG_ADDR_W-1:0] wa,
    output logic [XLEN-1:0]       wd
);

    seq_state_t      state;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    instr_u          ir;
    logic [XLEN-1:0] pend_target;
    logic            pend_valid;
    logic            mem_op;
    logic            advance;
    logic [XLEN-1:0] next_pc;

    assign pc_plus4 = pc + XLEN'(4);
    assign mem_op   = is_load | is_store;

    // Instruction retires at end of EXEC, or when its memory transfer completes
    assign advance = (state == EXEC && !mem_op) || (state == MEM && !waitrequest);
    assign next_pc = pend_valid ? pend_target : pc_plus4;

    // Operands for the execute units
    assign rs_addr     = ir.r.rs;
    assign rt_addr     = ir.r.rt;
    assign ex.instr    = ir;
    assign ex.rs_val   = rs_val;
    assign ex.rt_val   = rt_val;
    assign ex.pc_plus4 = pc_plus4;

    assign active     = (state != HALTED);
    assign byteenable = 4'b1111;
    assign writedata  = rt_val;

    // Bus request, held stable while waitrequest is high
    always_comb begin
        address = pc;
        read    = 1'b0;
        write   = 1'b0;
        case (state)
            FETCH: read = (pc != '0);
            MEM: begin
                address = mem_addr;
                read    = is_load;
                write   = is_store;
            end
            default: read = 1'b0;
        endcase
    end

    // Writeback, a link never coincides with an ALU write
    always_comb begin
        we = 1'b0;
        wa = wr_reg;
        wd = readdata;
        if (state == EXEC) begin
            we = link_en | wr_en;
            wa = link_en ? link_reg : wr_reg;
            wd = link_en ? link_val : result;
        end else if (state == MEM && is_load) begin
            we = !waitrequest;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= FETCH;
            pc         <= RESET_VECTOR;
            pend_valid <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (pc == '0) begin
                        state <= HALTED;
                    end else if (!waitrequest) begin
                        state <= EXEC;
                    end
                end
                EXEC:    state <= mem_op ? MEM : FETCH;
                MEM: begin
                    if (!waitrequest) begin
                        state <= FETCH;
                    end
                end
                default: state <= HALTED;
            endcase
            // A taken branch arms the target for after its delay slot
            if (advance) begin
                pc         <= next_pc;
                pend_valid <= redirect;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && !waitrequest) begin
            ir <= instr_u'(readdata);
        end
        if (advance) begin
            pend_target <= target;
        end
    end

endmodule

// File: logic/exec_if.sv
`timescale 1ns/1ps

interface exec_if import mips_pkg::*; ();

    // Instruction under execution and its operands
    instr_u          instr;
    logic [XLEN-1:0] rs_val;
    logic [XLEN-1:0] rt_val;
    logic [XLEN-1:0] pc_plus4;

    modport seq (
        output instr,
        output rs_val,
        output rt_val,
        output pc_plus4
    );

    modport alu (
        input instr,
        input rs_val,
        input rt_val
    );

    // Branch compares both operands and needs the sequential pc
    modport branch (
        input instr,
        input rs_val,
        input rt_val,
        input pc_plus4
    );

endinterface

// File: logic/mips_cpu_bus.sv
`timescale 1ns/1ps

module mips_cpu_bus import mips_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_VECTOR = 32'hBFC0_0000
) (
    input  logic            clk,
    input  logic            reset,
    output logic            active,
    output logic [XLEN-1:0] register_v0,
    output logic [XLEN-1:0] address,
    output logic            write,
    output logic            read,
    input  logic            waitrequest,
    output logic [XLEN-1:0] writedata,
    output logic [3:0]      byteenable,
    input  logic [XLEN-1:0] readdata
);

    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [XLEN-1:0]       rs_val;
    logic [XLEN-1:0]       rt_val;
    logic                  we;
    logic [REG_ADDR_W-1:0] wa;
    logic [XLEN-1:0]       wd;

    // ALU results
    logic [XLEN-1:0]       result;
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_reg;
    logic [XLEN-1:0]       mem_addr;
    logic                  is_load;
    logic                  is_store;

    // Branch unit results
    logic                  redirect;
    logic [XLEN-1:0]       target;
    logic                  link_en;
    logic [REG_ADDR_W-1:0] link_reg;
    logic [XLEN-1:0]       link_val;

    exec_if ex_bus ();

    register_file regs_i (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .we      (we),
        .wa      (wa),
        .wd      (wd),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .v0      (register_v0)
    );

    alu_unit alu_i (
        .ex       (ex_bus.alu),
        .result   (result),
        .wr_en    (wr_en),
        .wr_reg   (wr_reg),
        .mem_addr (mem_addr),
        .is_load  (is_load),
        .is_store (is_store)
    );

    branch_unit branch_i (
        .ex       (ex_bus.branch),
        .redirect (redirect),
        .target   (target),
        .link_en  (link_en),
        .link_reg (link_reg),
        .link_val (link_val)
    );

    bus_sequencer #(
        .RESET_VECTOR (RESET_VECTOR)
    ) seq_i (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .address     (address),
        .read        (read),
        .write       (write),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_val      (rs_val),
        .rt_val      (rt_val),
        .ex          (ex_bus.seq),
        .result      (result),
        .wr_en       (wr_en),
        .wr_reg      (wr_reg),
        .mem_addr    (mem_addr),
        .is_load     (is_load),
        .is_store    (is_store),
        .redirect    (redirect),
        .target      (target),
        .link_en     (link_en),
        .link_reg    (link_reg),
        .link_val    (link_val),
        .we          (we),
        .wa          (wa),
        .wd          (wd)
    );

endmodule

// File: logic/mips_pkg.sv
package mips_pkg;

    // Word and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [REG_ADDR_W-1:0] REG_V0 = 5'd2;
    localparam logic [REG_ADDR_W-1:0] REG_RA = 5'd31;

    // Primary opcodes that the core implements
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0A,
        OP_SLTIU = 6'h0B,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    // Function field of R-type instructions
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_t;

    typedef struct packed {
        opcode_t               opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        funct_t                funct;
    } r_view_t;

    typedef struct packed {
        opcode_t               opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } i_view_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] index;
    } j_view_t;

    // One instruction word seen in its three encodings
    typedef union packed {
        r_view_t r;
        i_view_t i;
        j_view_t j;
    } instr_u;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        HALTED
    } seq_state_t;

endpackage

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file import mips_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] rs_addr,
    input  logic [REG_ADDR_W-1:0] rt_addr,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] wa,
    input  logic [XLEN-1:0]       wd,
    output logic [XLEN-1:0]       rs_val,
    output logic [XLEN-1:0]       rt_val,
    output logic [XLEN-1:0]       v0
);

    // Register zero has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Asynchronous read ports
    assign rs_val = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_val = (rt_addr == '0) ? '0 : regs[rt_addr];

    assign v0 = regs[REG_V0];

endmodule

// File: tb/tb_tests.svh
// Instruction encoders
function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                      input logic [4:0] rd, input logic [4:0] shamt,
                                      input logic [5:0] funct);
    return {6'h00, rs, rt, rd, shamt, funct};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [31:0] dest);
    return {op, dest[27:2]};
endfunction

task automatic emit(input logic [31:0] word);
    prog.push_back(word);
endtask

task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    emit(enc_i(OP_LUI, 5'd0, rd, value[31:16]));
    emit(enc_i(OP_ORI, rd, rd, value[15:0]));
endtask

// Jump to address zero with a NOP in the delay slot halts the core
task automatic end_program();
    emit(enc_r(5'd0, 5'd0, 5'd0, 5'd0, FN_JR));
    emit(32'h0);
endtask

task automatic pulse_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;
endtask

task automatic wait_halt();
    @(negedge clk);
    while (active !== 1'b0) begin
        @(negedge clk);
    end
endtask

task automatic run_program();
    for (int i = 0; i < PROG_WORDS; i++) begin
        imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
        dmem[i] = fill_word(DATA_BASE + 32'(i * 4));
    end
    pulse_reset();
    wait_halt();
endtask

// One R-type op with rs in $8 and rt in $9, result into v0
task automatic run_rop(input string name, input logic [5:0] funct, input logic [4:0] shamt,
                       input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp_v0);
    prog.delete();
    load_const(5'd8, a);
    load_const(5'd9, b);
    emit(enc_r(5'd8, 5'd9, 5'd2, shamt, funct));
    end_program();
    run_program();
    check_val(name, register_v0, exp_v0);
endtask

task automatic run_iop(input string name, input logic [5:0] op, input logic [31:0] a,
                       input logic [15:0] imm, input logic [31:0] exp_v0);
    prog.delete();
    load_const(5'd8, a);
    emit(enc_i(op, 5'd8, 5'd2, imm));
    end_program();
    run_program();
    check_val(name, register_v0, exp_v0);
endtask

task automatic test_rtype();
    logic [31:0] a;
    logic [31:0] b;
    a = 32'h8000_00F0;
    b = 32'h0F0F_3C3C;
    run_rop("register_v0 addu", FN_ADDU, 5'd0, a, b, 32'h8F0F_3D2C);
    run_rop("register_v0 subu", FN_SUBU, 5'd0, a, b, 32'h70F0_C4B4);
    run_rop("register_v0 and", FN_AND, 5'd0, a, b, 32'h0000_0030);
    run_rop("register_v0 or", FN_OR, 5'd0, a, b, 32'h8F0F_3CFC);
    run_rop("register_v0 xor", FN_XOR, 5'd0, a, b, 32'h8F0F_3CCC);
    // a is negative when signed, larger when unsigned
    run_rop("register_v0 slt", FN_SLT, 5'd0, a, b, 32'h1);
    run_rop("register_v0 sltu", FN_SLTU, 5'd0, a, b, 32'h0);
    run_rop("register_v0 sll", FN_SLL, 5'd4, a, b, 32'hF0F3_C3C0);
    run_rop("register_v0 srl", FN_SRL, 5'd8, b, a, 32'h0080_0000);
    run_rop("register_v0 sra", FN_SRA, 5'd8, b, a, 32'hFF80_0000);
endtask

task automatic test_immediate();
    run_iop("register_v0 addiu", OP_ADDIU, 32'd100, 16'hFFFD, 32'd97);
    run_iop("register_v0 andi", OP_ANDI, 32'hFFFF_FFFF, 16'h8421, 32'h0000_8421);
    run_iop("register_v0 ori", OP_ORI, 32'h1234_0000, 16'h8001, 32'h1234_8001);
    run_iop("register_v0 xori", OP_XORI, 32'hFFFF_0F0F, 16'hFFFF, 32'hFFFF_F0F0);
    run_iop("register_v0 slti", OP_SLTI, 32'd5, 16'hFFF0, 32'h0);
    run_iop("register_v0 slti neg", OP_SLTI, 32'hFFFF_FFE0, 16'hFFF0, 32'h1);
    // Only a sign-extended immediate lies above this operand
    run_iop("register_v0 sltiu", OP_SLTIU, 32'h0001_0000, 16'hFFF0, 32'h1);
    prog.delete();
    load_const(5'd2, 32'hDEAD_BEEF);
    end_program();
    run_program();
    check_val("register_v0 lui ori", register_v0, 32'hDEAD_BEEF);
endtask

task automatic test_memory();
    prog.delete();
    load_const(5'd8, DATA_BASE);
    load_const(5'd9, 32'hCAFE_F00D);
    emit(enc_i(OP_SW, 5'd8, 5'd9, 16'd8));
    emit(enc_i(OP_LW, 5'd8, 5'd2, 16'd8));
    end_program();
    run_program();
    check_val("dmem[2]", dmem[2], 32'hCAFE_F00D);
    check_val("dmem[1]", dmem[1], fill_word(DATA_BASE + 32'd4));
    check_val("dmem[3]", dmem[3], fill_word(DATA_BASE + 32'd12));
    check_val("register_v0 lw", register_v0, 32'hCAFE_F00D);
endtask

task automatic test_control();
    // Taken BEQ skips +4 and a not-taken BNE still runs +16
    prog.delete();
    emit(enc_i(OP_ADDIU, 5'd0, 5'd2, 16'd1));
    emit(enc_i(OP_BEQ, 5'd0, 5'd0, 16'd2));
    emit(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd2));
    emit(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd4));
    emit(enc_i(OP_BNE, 5'd0, 5'd0, 16'd2));
    emit(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd8));
    emit(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd16));
    end_program();
    run_program();
    check_val("register_v0 branch", register_v0, 32'd1 + 32'd2 + 32'd8 + 32'd16);
    // JAL to word 10, JALR through $11 to word 13 linking $10
    prog.delete();
    load_const(5'd11, RESET_VECTOR + 32'd52);
    emit(enc_j(OP_JAL, RESET_VECTOR + 32'd40));
    emit(enc_i(OP_ADDIU, 5'd0, 5'd2, 16'd1));
    emit(enc_r(5'd2, 5'd31, 5'd2, 5'd0, FN_ADDU));
    emit(enc_r(5'd11, 5'd0, 5'd10, 5'd0, FN_JALR));
    emit(32'h0);
    emit(enc_r(5'd2, 5'd10, 5'd2, 5'd0, FN_ADDU));
    end_program();
    emit(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd16));
    emit(enc_r(5'd31, 5'd0, 5'd0, 5'd0, FN_JR));
    emit(32'h0);
    emit(enc_i(OP_ADDIU, 5'd2, 5'd2, 16'd32));
    emit(enc_r(5'd10, 5'd0, 5'd0, 5'd0, FN_JR));
    emit(32'h0);
    run_program();
    check_val("register_v0 link", register_v0,
              32'd49 + (RESET_VECTOR + 32'd16) + (RESET_VECTOR + 32'd28));
endtask

task automatic test_stalls_and_reset();
    stalls_on = 1'b1;
    test_memory();
    test_control();
    stalls_on = 1'b0;
    repeat (5) begin
        @(negedge clk);
        check_val("active", 32'(active), 32'h0);
        check_val("read", 32'(read), 32'h0);
        check_val("write", 32'(write), 32'h0);
    end
    pulse_reset();
    check_val("address", address, RESET_VECTOR);
    check_val("read", 32'(read), 32'h1);
    check_val("register_v0 reset", register_v0, 32'h0);
    wait_halt();
endtask

// File: tb/tb_mips_cpu.sv
`timescale 1ns/1ps

module tb_mips_cpu;

    localparam logic [31:0] RESET_VECTOR    = 32'hBFC0_0000;
    localparam logic [31:0] DATA_BASE       = 32'h1000_0000;
    localparam int          PROG_WORDS      = 256;
    localparam int          DATA_WORDS      = 64;
    localparam int          CLK_PERIOD      = 8;
    localparam int          NUM_TESTS       = 5;
    localparam int          CYCLES_PER_TEST = 4000;

    // Opcodes and function codes used to assemble the programs
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0A;
    localparam logic [5:0] OP_SLTIU = 6'h0B;
    localparam logic [5:0] OP_ANDI  = 6'h0C;
    localparam logic [5:0] OP_ORI   = 6'h0D;
    localparam logic [5:0] OP_XORI  = 6'h0E;
    localparam logic [5:0] OP_LUI   = 6'h0F;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_SRA   = 6'h03;
    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_JALR  = 6'h09;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2A;
    localparam logic [5:0] FN_SLTU  = 6'h2B;

    logic        clk;
    logic        reset;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;

    logic [31:0] imem [PROG_WORDS];
    logic [31:0] dmem [DATA_WORDS];
    logic [31:0] prog [$];
    logic [31:0] lcg_state;
    logic [31:0] rnd;
    bit          stalls_on;
    bit          in_xfer;
    int          stall_left;
    int          errors;
    int          checks;

    mips_cpu_bus #(
        .RESET_VECTOR (RESET_VECTOR)
    ) dut_i (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Untouched data words hold a value derived from their address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5A5A_A5A5;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] poff;
        logic [31:0] doff;
        poff = addr - RESET_VECTOR;
        doff = addr - DATA_BASE;
        if (poff < 32'(PROG_WORDS * 4)) begin
            return imem[poff[9:2]];
        end else if (doff < 32'(DATA_WORDS * 4)) begin
            return dmem[doff[7:2]];
        end
        return 32'h0;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, expected);
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] doff;
        doff = addr - DATA_BASE;
        check_val("byteenable", 32'(byteenable), 32'hF);
        assert (doff < 32'(DATA_WORDS * 4)) else begin
            errors++;
            $display("Store to address %h lies outside the data region", addr);
        end
        if (doff < 32'(DATA_WORDS * 4)) begin
            dmem[doff[7:2]] = data;
        end
    endtask

    // Avalon slave grants a transfer at the negedge before its completing edge
    always @(negedge clk) begin
        if (read === 1'b1 || write === 1'b1) begin
            if (!in_xfer) begin
                in_xfer = 1'b1;
                rnd = next_rand();
                stall_left = stalls_on ? int'(rnd[17:16]) : 0;
            end
            if (stall_left > 0) begin
                waitrequest = 1'b1;
                stall_left--;
            end else begin
                waitrequest = 1'b0;
                in_xfer = 1'b0;
                if (write === 1'b1) begin
                    write_word(address, writedata);
                end else begin
                    readdata = read_word(address);
                end
            end
        end else begin
            waitrequest = 1'b1;
        end
    end

    `include "tb_tests.svh"

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog expired: the processor did not halt in time");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        waitrequest = 1'b1;
        readdata = 32'h0;
        stalls_on = 1'b0;
        in_xfer = 1'b0;
        stall_left = 0;
        lcg_state = 32'd56;
        errors = 0;
        checks = 0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            imem[i] = 32'h0;
        end
        repeat (4) @(negedge clk);
        test_rtype();
        test_immediate();
        test_memory();
        test_control();
        test_stalls_and_reset();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
